/* logic/id_pkg.sv */
`default_nettype none

package id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam reg_addr_t LINK_REG = 5'd31;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// function field of SPECIAL
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// rt sub-codes of REGIMM, rs/rt of the unconditional forms
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;
	localparam logic [4:0] RS_BAL    = 5'b00000;
	localparam logic [4:0] RS_B      = 5'b00000;
	localparam logic [4:0] RT_B      = 5'b00000;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'h00,
		ALU_OR     = 8'h01,
		ALU_AND    = 8'h02,
		ALU_XOR    = 8'h03,
		ALU_NOR    = 8'h04,
		ALU_ORI    = 8'h05,
		ALU_ANDI   = 8'h06,
		ALU_XORI   = 8'h07,
		ALU_LUI    = 8'h08,
		ALU_ADD    = 8'h10,
		ALU_ADDU   = 8'h11,
		ALU_SUB    = 8'h12,
		ALU_SUBU   = 8'h13,
		ALU_ADDI   = 8'h14,
		ALU_ADDIU  = 8'h15,
		ALU_SLT    = 8'h18,
		ALU_SLTU   = 8'h19,
		ALU_SLTI   = 8'h1a,
		ALU_SLTIU  = 8'h1b,
		ALU_LB     = 8'h20,
		ALU_LH     = 8'h21,
		ALU_LW     = 8'h23,
		ALU_SB     = 8'h28,
		ALU_SH     = 8'h29,
		ALU_SW     = 8'h2b,
		ALU_J      = 8'h30,
		ALU_JAL    = 8'h31,
		ALU_JR     = 8'h32,
		ALU_JALR   = 8'h33,
		ALU_B      = 8'h40,
		ALU_BAL    = 8'h41,
		ALU_BEQ    = 8'h42,
		ALU_BNE    = 8'h43,
		ALU_BGTZ   = 8'h44,
		ALU_BLEZ   = 8'h45,
		ALU_BLTZ   = 8'h46,
		ALU_BLTZAL = 8'h47,
		ALU_BGEZ   = 8'h48,
		ALU_BGEZAL = 8'h49
	} alu_op_e;

	// zero encodings double as "nothing" in a bubble
	typedef enum logic [1:0] {
		OPND2_NONE = 2'd0,
		OPND2_REG  = 2'd1,
		OPND2_ZIMM = 2'd2,
		OPND2_SIMM = 2'd3
	} opnd2_sel_e;

	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_J    = 4'd1,
		BR_JR   = 4'd2,
		BR_B    = 4'd3,
		BR_BEQ  = 4'd4,
		BR_BNE  = 4'd5,
		BR_BGTZ = 4'd6,
		BR_BLEZ = 4'd7,
		BR_BLTZ = 4'd8,
		BR_BGEZ = 4'd9
	} branch_kind_e;

	typedef struct packed {
		logic      rd1_en;
		logic      rd2_en;
		reg_addr_t rd1_addr;
		reg_addr_t rd2_addr;
	} rf_read_t;

	// result held by a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_src_t;

	typedef struct packed {
		rf_read_t     rf;
		alu_op_e      alu_op;
		opnd2_sel_e   opnd2_sel;
		logic         store;
		reg_addr_t    waddr;
		logic         wreg;
		branch_kind_e br_kind;
		logic         link;
	} dec_ctrl_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} branch_t;

	typedef struct packed {
		alu_op_e   alu_op;
		word_t     opnd1;
		word_t     opnd2;
		reg_addr_t waddr;
		logic      wreg;
		word_t     inst;
		word_t     return_addr;
	} id_ex_t;

	localparam id_ex_t ID_EX_BUBBLE = '0;

	function automatic logic is_load(input alu_op_e op);
		return (op == ALU_LW) || (op == ALU_LH) || (op == ALU_LB);
	endfunction

endpackage

`default_nettype wire

/* logic/inst_decoder.sv */
`default_nettype none

module inst_decoder (
	input  wire id_pkg::word_t     inst_i,
	output id_pkg::dec_ctrl_t      ctrl_o
);

	import id_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign funct  = inst_i[5:0];

	// operation for the opcodes that need no sub-code
	function automatic alu_op_e opcode_op(input logic [5:0] op);
		case (op)
			OP_ORI:   return ALU_ORI;
			OP_ANDI:  return ALU_ANDI;
			OP_XORI:  return ALU_XORI;
			OP_LUI:   return ALU_LUI;
			OP_ADDI:  return ALU_ADDI;
			OP_ADDIU: return ALU_ADDIU;
			OP_SLTI:  return ALU_SLTI;
			OP_SLTIU: return ALU_SLTIU;
			OP_LB:    return ALU_LB;
			OP_LH:    return ALU_LH;
			OP_LW:    return ALU_LW;
			OP_SB:    return ALU_SB;
			OP_SH:    return ALU_SH;
			OP_SW:    return ALU_SW;
			OP_J:     return ALU_J;
			OP_JAL:   return ALU_JAL;
			OP_BNE:   return ALU_BNE;
			OP_BGTZ:  return ALU_BGTZ;
			OP_BLEZ:  return ALU_BLEZ;
			default:  return ALU_NOP;
		endcase
	endfunction

	function automatic alu_op_e funct_op(input logic [5:0] fn);
		case (fn)
			FN_AND:  return ALU_AND;
			FN_OR:   return ALU_OR;
			FN_XOR:  return ALU_XOR;
			FN_NOR:  return ALU_NOR;
			FN_ADD:  return ALU_ADD;
			FN_ADDU: return ALU_ADDU;
			FN_SUB:  return ALU_SUB;
			FN_SUBU: return ALU_SUBU;
			FN_SLT:  return ALU_SLT;
			FN_SLTU: return ALU_SLTU;
			FN_JR:   return ALU_JR;
			FN_JALR: return ALU_JALR;
			default: return ALU_NOP;
		endcase
	endfunction

	always_comb begin
		ctrl_o = '0;
		case (opcode)
			OP_SPECIAL: begin
				ctrl_o.alu_op = funct_op(funct);
				if (ctrl_o.alu_op == ALU_JR || ctrl_o.alu_op == ALU_JALR) begin
					ctrl_o.rf.rd1_en   = 1'b1;
					ctrl_o.rf.rd1_addr = rs;
					ctrl_o.br_kind     = BR_JR;
					// jalr links into rd, not r31
					ctrl_o.link  = (funct == FN_JALR);
					ctrl_o.waddr = ctrl_o.link ? rd : '0;
					ctrl_o.wreg  = ctrl_o.link;
				end else if (ctrl_o.alu_op != ALU_NOP) begin
					ctrl_o.rf        = '{rd1_en: 1'b1, rd2_en: 1'b1, rd1_addr: rs, rd2_addr: rt};
					ctrl_o.opnd2_sel = OPND2_REG;
					ctrl_o.waddr     = rd;
					ctrl_o.wreg      = 1'b1;
				end
			end
			OP_REGIMM: begin
				case (rt)
					RT_BLTZ: begin
						ctrl_o.alu_op  = ALU_BLTZ;
						ctrl_o.br_kind = BR_BLTZ;
					end
					RT_BGEZ: begin
						ctrl_o.alu_op  = ALU_BGEZ;
						ctrl_o.br_kind = BR_BGEZ;
					end
					RT_BLTZAL: begin
						ctrl_o.alu_op  = ALU_BLTZAL;
						ctrl_o.br_kind = BR_BLTZ;
						ctrl_o.link    = 1'b1;
					end
					RT_BGEZAL: begin
						ctrl_o.link = 1'b1;
						if (rs == RS_BAL) begin
							ctrl_o.alu_op  = ALU_BAL;
							ctrl_o.br_kind = BR_B;
						end else begin
							ctrl_o.alu_op  = ALU_BGEZAL;
							ctrl_o.br_kind = BR_BGEZ;
						end
					end
					default: ;
				endcase
				// bal tests nothing
				if (ctrl_o.br_kind != BR_NONE && ctrl_o.br_kind != BR_B) begin
					ctrl_o.rf.rd1_en   = 1'b1;
					ctrl_o.rf.rd1_addr = rs;
				end
				if (ctrl_o.link) begin
					ctrl_o.waddr = LINK_REG;
					ctrl_o.wreg  = 1'b1;
				end
			end
			OP_J, OP_JAL: begin
				ctrl_o.alu_op  = opcode_op(opcode);
				ctrl_o.br_kind = BR_J;
				ctrl_o.link    = (opcode == OP_JAL);
				ctrl_o.waddr   = ctrl_o.link ? LINK_REG : '0;
				ctrl_o.wreg    = ctrl_o.link;
			end
			OP_BEQ, OP_BNE: begin
				if (opcode == OP_BEQ && rs == RS_B && rt == RT_B) begin
					// beq r0, r0 is the unconditional b
					ctrl_o.alu_op  = ALU_B;
					ctrl_o.br_kind = BR_B;
				end else begin
					ctrl_o.alu_op    = (opcode == OP_BEQ) ? ALU_BEQ : opcode_op(opcode);
					ctrl_o.br_kind   = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
					ctrl_o.rf        = '{rd1_en: 1'b1, rd2_en: 1'b1, rd1_addr: rs, rd2_addr: rt};
					ctrl_o.opnd2_sel = OPND2_REG;
				end
			end
			OP_BGTZ, OP_BLEZ: begin
				ctrl_o.alu_op      = opcode_op(opcode);
				ctrl_o.br_kind     = (opcode == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
				ctrl_o.rf.rd1_en   = 1'b1;
				ctrl_o.rf.rd1_addr = rs;
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_LB, OP_LH, OP_LW: begin
				ctrl_o.alu_op = opcode_op(opcode);
				// lui has no source register
				ctrl_o.rf.rd1_en   = (opcode != OP_LUI);
				ctrl_o.rf.rd1_addr = (opcode != OP_LUI) ? rs : '0;
				// logical forms zero-extend
				if (opcode inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI})
					ctrl_o.opnd2_sel = OPND2_ZIMM;
				else
					ctrl_o.opnd2_sel = OPND2_SIMM;
				ctrl_o.waddr = rt;
				ctrl_o.wreg  = 1'b1;
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl_o.alu_op    = opcode_op(opcode);
				ctrl_o.rf        = '{rd1_en: 1'b1, rd2_en: 1'b1, rd1_addr: rs, rd2_addr: rt};
				ctrl_o.opnd2_sel = OPND2_REG;
				ctrl_o.store     = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`default_nettype none

module operand_forward (
	input  wire id_pkg::reg_addr_t rd_addr_i,
	input  wire                    rd_en_i,
	input  wire id_pkg::word_t     rf_data_i,
	input  wire id_pkg::wb_src_t   ex_src_i,
	input  wire id_pkg::wb_src_t   mem_src_i,
	input  wire id_pkg::alu_op_e   ex_alu_op_i,
	output id_pkg::word_t          opnd_o,
	output logic                   hazard_o
);

	import id_pkg::*;

	logic ex_hit;
	logic mem_hit;
	logic load_hit;

	// r0 is hardwired, never forwarded
	assign ex_hit  = ex_src_i.wreg && (ex_src_i.waddr != '0) && (ex_src_i.waddr == rd_addr_i);
	assign mem_hit = mem_src_i.wreg && (mem_src_i.waddr != '0) && (mem_src_i.waddr == rd_addr_i);

	// load result is not ready until after mem
	assign load_hit = is_load(ex_alu_op_i) && (ex_src_i.waddr != '0)
		&& (ex_src_i.waddr == rd_addr_i);

	always_comb begin
		opnd_o   = '0;
		hazard_o = 1'b0;
		if (rd_en_i) begin
			hazard_o = load_hit;
			if (ex_hit)
				opnd_o = ex_src_i.wdata;
			else if (mem_hit)
				opnd_o = mem_src_i.wdata;
			else
				opnd_o = rf_data_i;
		end
	end

endmodule

`default_nettype wire

/* logic/branch_resolve.sv */
`default_nettype none

module branch_resolve (
	input  wire id_pkg::branch_kind_e kind_i,
	input  wire                       link_i,
	input  wire id_pkg::word_t        pc_i,
	input  wire id_pkg::word_t        inst_i,
	input  wire id_pkg::word_t        opnd1_i,
	input  wire id_pkg::word_t        opnd2_i,
	input  wire                       stall_i,
	output id_pkg::branch_t           branch_o,
	output id_pkg::word_t             return_addr_o
);

	import id_pkg::*;

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t j_target;
	word_t b_target;
	word_t target;
	logic  cond_taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;

	// region of the delay slot plus 26-bit index
	assign j_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
	assign b_target = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		case (kind_i)
			BR_J:    target = j_target;
			BR_JR:   target = opnd1_i;
			default: target = b_target;
		endcase
	end

	always_comb begin
		case (kind_i)
			BR_J, BR_JR, BR_B: cond_taken = 1'b1;
			BR_BEQ:            cond_taken = (opnd1_i == opnd2_i);
			BR_BNE:            cond_taken = (opnd1_i != opnd2_i);
			BR_BGTZ:           cond_taken = ($signed(opnd1_i) > 32'sd0);
			BR_BLEZ:           cond_taken = ($signed(opnd1_i) <= 32'sd0);
			BR_BLTZ:           cond_taken = opnd1_i[31];
			BR_BGEZ:           cond_taken = !opnd1_i[31];
			default:           cond_taken = 1'b0;
		endcase
	end

	// operands may be stale while stalled, so hold the redirect back
	assign branch_o.taken  = cond_taken && !stall_i;
	assign branch_o.target = branch_o.taken ? target : '0;

	// jal and jalr are always taken, so they always link
	assign return_addr_o = (link_i && cond_taken) ? pc_plus_8 : '0;

endmodule

`default_nettype wire

/* logic/id_ex_reg.sv */
`default_nettype none

module id_ex_reg (
	input  wire                 clk,
	input  wire                 reset_i,
	input  wire                 stall_i,
	input  wire id_pkg::id_ex_t d_i,
	output id_pkg::id_ex_t      q_o
);

	import id_pkg::*;

	// a stalled instruction is replayed, so ex gets a bubble
	always_ff @(posedge clk) begin
		if (reset_i || stall_i) begin
			q_o <= ID_EX_BUBBLE;
		end else begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

/* logic/id_stage.sv */
`default_nettype none

module id_stage (
	input  wire                   clk,
	input  wire                   reset_i,
	input  wire id_pkg::word_t    pc_i,
	input  wire id_pkg::word_t    inst_i,
	input  wire id_pkg::word_t    rf_data1_i,
	input  wire id_pkg::word_t    rf_data2_i,
	input  wire id_pkg::wb_src_t  ex_src_i,
	input  wire id_pkg::wb_src_t  mem_src_i,
	input  wire id_pkg::alu_op_e  ex_alu_op_i,
	output id_pkg::rf_read_t      rf_read_o,
	output id_pkg::branch_t       branch_o,
	output logic                  stall_o,
	output id_pkg::id_ex_t        id_ex_o
);

	import id_pkg::*;

	dec_ctrl_t ctrl;
	word_t     opnd1_fwd;
	word_t     opnd2_fwd;
	word_t     zimm;
	word_t     simm;
	word_t     return_addr;
	logic      hazard1;
	logic      hazard2;
	id_ex_t    id_ex_d;

	inst_decoder u_dec (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	assign rf_read_o = ctrl.rf;

	operand_forward fwd1 (
		.rd_en_i     (ctrl.rf.rd1_en),
		.rd_addr_i   (ctrl.rf.rd1_addr),
		.rf_data_i   (rf_data1_i),
		.ex_src_i    (ex_src_i),
		.mem_src_i   (mem_src_i),
		.ex_alu_op_i (ex_alu_op_i),
		.opnd_o      (opnd1_fwd),
		.hazard_o    (hazard1)
	);

	operand_forward fwd2 (
		.rd_en_i     (ctrl.rf.rd2_en),
		.rd_addr_i   (ctrl.rf.rd2_addr),
		.rf_data_i   (rf_data2_i),
		.ex_src_i    (ex_src_i),
		.mem_src_i   (mem_src_i),
		.ex_alu_op_i (ex_alu_op_i),
		.opnd_o      (opnd2_fwd),
		.hazard_o    (hazard2)
	);

	assign stall_o = hazard1 | hazard2;

	branch_resolve u_br (
		.kind_i        (ctrl.br_kind),
		.link_i        (ctrl.link),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.opnd1_i       (opnd1_fwd),
		.opnd2_i       (opnd2_fwd),
		.stall_i       (stall_o),
		.branch_o      (branch_o),
		.return_addr_o (return_addr)
	);

	assign zimm = {16'h0000, inst_i[15:0]};
	assign simm = {{16{inst_i[15]}}, inst_i[15:0]};

	always_comb begin
		id_ex_d.alu_op = ctrl.alu_op;
		// stores carry the effective address; lui reads nothing so opnd1 is zero
		id_ex_d.opnd1 = ctrl.store ? (opnd1_fwd + simm) : opnd1_fwd;
		case (ctrl.opnd2_sel)
			OPND2_REG:  id_ex_d.opnd2 = opnd2_fwd;
			OPND2_ZIMM: id_ex_d.opnd2 = zimm;
			OPND2_SIMM: id_ex_d.opnd2 = simm;
			default:    id_ex_d.opnd2 = '0;
		endcase
		id_ex_d.waddr = ctrl.waddr;
		id_ex_d.wreg  = ctrl.wreg;
		// unknown encodings travel as a plain bubble
		id_ex_d.inst        = (ctrl.alu_op == ALU_NOP) ? '0 : inst_i;
		id_ex_d.return_addr = return_addr;
	end

	id_ex_reg u_id_ex (
		.clk     (clk),
		.reset_i (reset_i),
		.stall_i (stall_o),
		.d_i     (id_ex_d),
		.q_o     (id_ex_o)
	);

endmodule

`default_nettype wire

/* tests/id_stage_props.sv */
`default_nettype none

module id_stage_props (
	input wire                  clk,
	input wire                  reset_i,
	input wire                  stall_o,
	input wire id_pkg::branch_t branch_o,
	input wire id_pkg::id_ex_t  id_ex_o
);

	timeunit 1ns;
	timeprecision 1ps;

	import id_pkg::*;

	// stalled instruction must not reach ex
	stall_gives_bubble: assert property (@(posedge clk) stall_o |=> id_ex_o == ID_EX_BUBBLE)
		else $error("id_ex_o is not a bubble one cycle after a stall");

	no_redirect_while_stalled: assert property (@(posedge clk) !(branch_o.taken && stall_o))
		else $error("branch taken while the stage is stalled");

	reset_gives_bubble: assert property (@(posedge clk) reset_i |=> id_ex_o == ID_EX_BUBBLE)
		else $error("id_ex_o is not a bubble after reset");

endmodule

bind id_stage id_stage_props u_props (
	.clk      (clk),
	.reset_i  (reset_i),
	.stall_o  (stall_o),
	.branch_o (branch_o),
	.id_ex_o  (id_ex_o)
);

`default_nettype wire

/* tests/tb_id_stage.sv */
`default_nettype none

module tb_id_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import id_pkg::*;

	localparam int MAX_CYCLES  = 2000;
	localparam int MIN_VECTORS = 40;

	logic      clk;
	logic      reset_i;
	word_t     pc;
	word_t     inst;
	word_t     rf_data1;
	word_t     rf_data2;
	wb_src_t   ex_src;
	wb_src_t   mem_src;
	alu_op_e   ex_alu_op;
	rf_read_t  rf_read;
	branch_t   branch;
	logic      stall;
	id_ex_t    id_ex;

	int cycle_count;
	int vec_count;

	// one trace vector, stimulus side
	word_t      s_pc;
	word_t      s_inst;
	word_t      s_rf1;
	word_t      s_rf2;
	logic       s_exw;
	reg_addr_t  s_exa;
	word_t      s_exd;
	logic       s_memw;
	reg_addr_t  s_mema;
	word_t      s_memd;
	logic [7:0] s_exop;

	// expected side
	logic       e_rd1en;
	logic       e_rd2en;
	reg_addr_t  e_rd1a;
	reg_addr_t  e_rd2a;
	logic       e_stall;
	logic       e_taken;
	word_t      e_target;
	logic [7:0] e_aluop;
	word_t      e_op1;
	word_t      e_op2;
	reg_addr_t  e_waddr;
	logic       e_wreg;
	word_t      e_inst;
	word_t      e_ret;

	id_stage uut (
		.clk         (clk),
		.reset_i     (reset_i),
		.pc_i        (pc),
		.inst_i      (inst),
		.rf_data1_i  (rf_data1),
		.rf_data2_i  (rf_data2),
		.ex_src_i    (ex_src),
		.mem_src_i   (mem_src),
		.ex_alu_op_i (ex_alu_op),
		.rf_read_o   (rf_read),
		.branch_o    (branch),
		.stall_o     (stall),
		.id_ex_o     (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rf_read(input rf_read_t got, input rf_read_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("ERROR at %0t ns: %s got %h, expected %h (vector %0d)",
				$time, what, got, exp, vec_count));
	endtask

	task automatic check_branch(input branch_t got, input branch_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("ERROR at %0t ns: %s got %b %h, expected %b %h (vector %0d)",
				$time, what, got.taken, got.target, exp.taken, exp.target, vec_count));
	endtask

	task automatic check_stall(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("ERROR at %0t ns: %s got %b, expected %b (vector %0d)",
				$time, what, got, exp, vec_count));
	endtask

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("ERROR at %0t ns: %s got %h, expected %h (vector %0d)",
				$time, what, got, exp, vec_count));
	endtask

	// an all-zero word decodes as a dropped shift, i.e. a bubble
	task automatic drive_idle();
		@(posedge clk);
		pc        <= '0;
		inst      <= '0;
		rf_data1  <= '0;
		rf_data2  <= '0;
		ex_src    <= '0;
		mem_src   <= '0;
		ex_alu_op <= ALU_NOP;
		@(negedge clk);
		check_rf_read(rf_read, '0, "idle rf_read_o");
		check_stall(stall, 1'b0, "idle stall_o");
		check_branch(branch, '0, "idle branch_o");
		@(posedge clk);
		@(negedge clk);
		check_id_ex(id_ex, ID_EX_BUBBLE, "idle id_ex_o");
	endtask

	task automatic run_vector();
		rf_read_t exp_rf;
		branch_t  exp_br;
		id_ex_t   exp_idex;
		exp_rf.rd1_en        = e_rd1en;
		exp_rf.rd2_en        = e_rd2en;
		exp_rf.rd1_addr      = e_rd1a;
		exp_rf.rd2_addr      = e_rd2a;
		exp_br.taken         = e_taken;
		exp_br.target        = e_target;
		exp_idex.alu_op      = alu_op_e'(e_aluop);
		exp_idex.opnd1       = e_op1;
		exp_idex.opnd2       = e_op2;
		exp_idex.waddr       = e_waddr;
		exp_idex.wreg        = e_wreg;
		exp_idex.inst        = e_inst;
		exp_idex.return_addr = e_ret;
		@(posedge clk);
		pc        <= s_pc;
		inst      <= s_inst;
		rf_data1  <= s_rf1;
		rf_data2  <= s_rf2;
		ex_src    <= '{wreg: s_exw, waddr: s_exa, wdata: s_exd};
		mem_src   <= '{wreg: s_memw, waddr: s_mema, wdata: s_memd};
		ex_alu_op <= alu_op_e'(s_exop);
		// combinational outputs settle mid-cycle
		@(negedge clk);
		check_rf_read(rf_read, exp_rf, "rf_read_o");
		check_stall(stall, e_stall, "stall_o");
		check_branch(branch, exp_br, "branch_o");
		@(posedge clk);
		@(negedge clk);
		check_id_ex(id_ex, exp_idex, "id_ex_o");
	endtask

	// beq r1, r2 with equal operands while a load to r2 sits in ex
	task automatic run_stalled_branch();
		s_pc     = 32'h0040_0100;
		s_inst   = 32'h1022_0004;
		s_rf1    = 32'h0000_0005;
		s_rf2    = 32'h0000_0005;
		s_exw    = 1'b1;
		s_exa    = 5'd2;
		s_exd    = 32'h0000_0005;
		s_memw   = 1'b0;
		s_mema   = '0;
		s_memd   = '0;
		s_exop   = ALU_LW;
		e_rd1en  = 1'b1;
		e_rd2en  = 1'b1;
		e_rd1a   = 5'd1;
		e_rd2a   = 5'd2;
		e_stall  = 1'b1;
		e_taken  = 1'b0;
		e_target = '0;
		e_aluop  = ALU_NOP;
		e_op1    = '0;
		e_op2    = '0;
		e_waddr  = '0;
		e_wreg   = 1'b0;
		e_inst   = '0;
		e_ret    = '0;
		run_vector();
	endtask

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		fail_run("timeout: the run did not finish within the cycle limit");
	end

	initial begin
		int    fd;
		int    n;
		int    rst_cycles;
		bit    have_stim;
		string line;
		reset_i   = 1'b1;
		pc        = '0;
		// an ori is presented while reset is held
		inst      = 32'h3422ffff;
		rf_data1  = 32'h0000_0005;
		rf_data2  = '0;
		ex_src    = '0;
		mem_src   = '0;
		ex_alu_op = ALU_NOP;
		vec_count = 0;
		have_stim = 1'b0;
		void'($urandom(32'hefe4));

		rst_cycles = 0;
		while (rst_cycles < 2) begin
			@(posedge clk);
			rst_cycles++;
		end
		reset_i <= 1'b0;
		@(negedge clk);
		check_id_ex(id_ex, ID_EX_BUBBLE, "id_ex_o after reset");

		fd = $fopen("tests/id_trace.txt", "r");
		if (fd == 0)
			fail_run("could not open the trace file tests/id_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == 8'h23 || line.getc(0) == 8'h0a)
				continue;
			if (line.getc(0) == 8'h53) begin
				n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h %h", s_pc, s_inst,
					s_rf1, s_rf2, s_exw, s_exa, s_exd, s_memw, s_mema, s_memd, s_exop);
				if (n != 11)
					fail_run("a stimulus line in the trace file has too few fields");
				have_stim = 1'b1;
			end else if (line.getc(0) == 8'h45) begin
				if (!have_stim)
					fail_run("the trace file has an expected line without a stimulus line");
				n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					e_rd1en, e_rd2en, e_rd1a, e_rd2a, e_stall, e_taken, e_target,
					e_aluop, e_op1, e_op2, e_waddr, e_wreg, e_inst, e_ret);
				if (n != 14)
					fail_run("an expected line in the trace file has too few fields");
				// random idle gaps between vectors
				if ($urandom % 4 == 0)
					drive_idle();
				run_vector();
				vec_count++;
				have_stim = 1'b0;
			end else begin
				fail_run("the trace file holds a line that is neither stimulus nor expected");
			end
		end
		$fclose(fd);
		if (have_stim)
			fail_run("the trace file ends with a stimulus line that has no expected line");

		run_stalled_branch();
		vec_count++;

		if (vec_count < MIN_VECTORS) begin
			fail_run($sformatf("the trace file is short, only %0d vectors", vec_count));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/id_trace.txt */
# S pc inst rf1 rf2 ex_wreg ex_waddr ex_wdata mem_wreg mem_waddr mem_wdata ex_alu_op
# E rd1en rd2en rd1a rd2a stall taken target alu_op opnd1 opnd2 waddr wreg inst return_addr
# immediate alu
S 00001000 3422ffff 00000005 12345678 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 05 00000005 0000ffff 02 1 3422ffff 00000000
S 00001000 30238000 ffffffff 00000000 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 06 ffffffff 00008000 03 1 30238000 00000000
S 00001000 38a400f0 0000000f 00000000 0 00 00000000 0 00 00000000 00
E 1 0 05 00 0 0 00000000 07 0000000f 000000f0 04 1 38a400f0 00000000
S 00001000 3c061234 aaaaaaaa 00000000 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 0 00000000 08 00000000 00001234 06 1 3c061234 00000000
S 00001000 2027fffc 00000010 00000000 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 14 00000010 fffffffc 07 1 2027fffc 00000000
S 00001000 24487fff 00000001 00000000 0 00 00000000 0 00 00000000 00
E 1 0 02 00 0 0 00000000 15 00000001 00007fff 08 1 24487fff 00000000
S 00001000 28698001 00000003 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 1a 00000003 ffff8001 09 1 28698001 00000000
S 00001000 2c6affff 00000003 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 1b 00000003 ffffffff 0a 1 2c6affff 00000000
# register alu
S 00001000 00225824 f0f0f0f0 ff00ff00 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 02 f0f0f0f0 ff00ff00 0b 1 00225824 00000000
S 00001000 00646025 0000000f 000000f0 0 00 00000000 0 00 00000000 00
E 1 1 03 04 0 0 00000000 01 0000000f 000000f0 0c 1 00646025 00000000
S 00001000 00a66826 aaaaaaaa 55555555 0 00 00000000 0 00 00000000 00
E 1 1 05 06 0 0 00000000 03 aaaaaaaa 55555555 0d 1 00a66826 00000000
S 00001000 00e87027 12345678 87654321 0 00 00000000 0 00 00000000 00
E 1 1 07 08 0 0 00000000 04 12345678 87654321 0e 1 00e87027 00000000
S 00001000 00227820 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 10 11111111 22222222 0f 1 00227820 00000000
S 00001000 00228021 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 11 11111111 22222222 10 1 00228021 00000000
S 00001000 00228822 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 12 11111111 22222222 11 1 00228822 00000000
S 00001000 00229023 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 13 11111111 22222222 12 1 00229023 00000000
S 00001000 0022982a 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 18 11111111 22222222 13 1 0022982a 00000000
S 00001000 0022a02b 11111111 22222222 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 19 11111111 22222222 14 1 0022a02b 00000000
# forwarding
S 00001000 00228021 11111111 22222222 1 01 dddddddd 1 01 eeeeeeee 11
E 1 1 01 02 0 0 00000000 11 dddddddd 22222222 10 1 00228021 00000000
S 00001000 00228021 11111111 22222222 1 05 dddddddd 1 02 eeeeeeee 11
E 1 1 01 02 0 0 00000000 11 11111111 eeeeeeee 10 1 00228021 00000000
S 00001000 00028021 11111111 22222222 1 00 dddddddd 1 00 eeeeeeee 11
E 1 1 00 02 0 0 00000000 11 11111111 22222222 10 1 00028021 00000000
# load-use
S 00001000 00228021 11111111 22222222 1 01 dddddddd 0 00 00000000 23
E 1 1 01 02 1 0 00000000 00 00000000 00000000 00 0 00000000 00000000
S 00400100 10220004 00000005 00000005 1 02 dddddddd 0 00 00000000 23
E 1 1 01 02 1 0 00000000 00 00000000 00000000 00 0 00000000 00000000
S 00001000 00028021 11111111 22222222 1 00 dddddddd 0 00 00000000 23
E 1 1 00 02 0 0 00000000 11 11111111 22222222 10 1 00028021 00000000
S 00001000 3422ffff 00000005 00000000 1 02 dddddddd 0 00 00000000 23
E 1 0 01 00 0 0 00000000 05 00000005 0000ffff 02 1 3422ffff 00000000
# jumps and branches
S 80000000 08100040 00000000 00000000 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 1 80400100 30 00000000 00000000 00 0 08100040 00000000
S 00400100 0c100040 00000000 00000000 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 1 00400100 31 00000000 00000000 1f 1 0c100040 00400108
S 00400100 03e00008 00400200 00000000 0 00 00000000 0 00 00000000 00
E 1 0 1f 00 0 1 00400200 32 00400200 00000000 00 0 03e00008 00000000
S 00400100 00802809 00001234 00000000 0 00 00000000 0 00 00000000 00
E 1 0 04 00 0 1 00001234 33 00001234 00000000 05 1 00802809 00400108
S 00400100 10000010 00000000 00000000 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 1 00400144 40 00000000 00000000 00 0 10000010 00000000
S 00400100 10220004 00000005 00000005 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 1 00400114 42 00000005 00000005 00 0 10220004 00000000
S 00400100 10220004 00000005 00000006 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 42 00000005 00000006 00 0 10220004 00000000
S 00400100 1422fffe 00000005 00000006 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 1 004000fc 43 00000005 00000006 00 0 1422fffe 00000000
S 00400100 1c600008 00000001 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 44 00000001 00000000 00 0 1c600008 00000000
S 00400100 1c600008 80000000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 44 80000000 00000000 00 0 1c600008 00000000
S 00400100 18600008 ffffffff 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 45 ffffffff 00000000 00 0 18600008 00000000
S 00400100 18600008 00000002 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 45 00000002 00000000 00 0 18600008 00000000
S 00400100 04600008 80000000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 46 80000000 00000000 00 0 04600008 00000000
S 00400100 04600008 7fffffff 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 46 7fffffff 00000000 00 0 04600008 00000000
S 00400100 04610008 00000000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 48 00000000 00000000 00 0 04610008 00000000
S 00400100 04610008 ffffffff 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 48 ffffffff 00000000 00 0 04610008 00000000
S 00400100 04700008 ffffffff 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 47 ffffffff 00000000 1f 1 04700008 00400108
S 00400100 04700008 00000001 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 0 00000000 47 00000001 00000000 1f 1 04700008 00000000
S 00400100 04710008 00000001 00000000 0 00 00000000 0 00 00000000 00
E 1 0 03 00 0 1 00400124 49 00000001 00000000 1f 1 04710008 00400108
S 00400100 04110008 00000000 00000000 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 1 00400124 41 00000000 00000000 1f 1 04110008 00400108
# loads and stores
S 00001000 8c240008 00002000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 23 00002000 00000008 04 1 8c240008 00000000
S 00001000 8425fffe 00002000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 21 00002000 fffffffe 05 1 8425fffe 00000000
S 00001000 80260001 00002000 00000000 0 00 00000000 0 00 00000000 00
E 1 0 01 00 0 0 00000000 20 00002000 00000001 06 1 80260001 00000000
S 00001000 ac220010 00002000 cafef00d 0 00 00000000 0 00 00000000 00
E 1 1 01 02 0 0 00000000 2b 00002010 cafef00d 00 0 ac220010 00000000
S 00001000 a423fffc 00002000 0000beef 0 00 00000000 0 00 00000000 00
E 1 1 01 03 0 0 00000000 29 00001ffc 0000beef 00 0 a423fffc 00000000
S 00001000 a0470003 00000100 000000ab 0 00 00000000 0 00 00000000 00
E 1 1 02 07 0 0 00000000 28 00000103 000000ab 00 0 a0470003 00000000
# unsupported encodings
S 00001000 00011080 11111111 22222222 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 0 00000000 00 00000000 00000000 00 0 00000000 00000000
S 00001000 fc000000 11111111 22222222 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 0 00000000 00 00000000 00000000 00 0 00000000 00000000
S 00001000 04620000 11111111 22222222 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 0 00000000 00 00000000 00000000 00 0 00000000 00000000
S 00001000 00221807 11111111 22222222 0 00 00000000 0 00 00000000 00
E 0 0 00 00 0 0 00000000 00 00000000 00000000 00 0 00000000 00000000

/* sim.f */
logic/id_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/id_stage.sv
tests/id_stage_props.sv
tests/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f sim.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_id_stage 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
